/* logic/shade_pkg.sv */
package shade_pkg;

    localparam int coord_w     = 12; // vertex coordinate
    localparam int edge_w      = 13; // difference of two coordinates
    localparam int norm_w      = 27; // difference of two edge products
    localparam int mag_w       = 56; // sum of three squared normal components
    localparam int fifo_depth  = 8;
    localparam int index_w     = 5;  // shade index 0..16
    localparam int shade_steps = 5;  // one quotient bit per divide cycle

    typedef logic signed [coord_w-1:0] coord_t;
    typedef logic signed [edge_w-1:0]  edge_t;
    typedef logic signed [norm_w-1:0]  norm_t;
    typedef logic [mag_w-1:0]          mag_t;
    typedef logic [index_w-1:0]        index_t;
    typedef logic [7:0]                color_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
        coord_t z;
    } vertex_t;

    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } triangle_t;

    typedef struct packed {
        norm_t nx;
        norm_t ny;
        norm_t nz;
    } normal_t;

    typedef enum logic [2:0] {
        idle,
        square,
        sum,
        divide,
        lookup
    } shade_state_t;

    localparam color_t color_back = 8'd255; // facing away from the viewer

    // grey level per floor(16 * cos^2), brightness falls off roughly linearly
    localparam color_t color_table [0:16] = '{
        8'd0,   8'd20,  8'd40,  8'd60,
        8'd78,  8'd96,  8'd114, 8'd130,
        8'd146, 8'd162, 8'd178, 8'd194,
        8'd210, 8'd226, 8'd242,
        8'd255, 8'd255  // top two saturate at 8 bits
    };

endpackage

/* logic/normal_calc.sv */
`timescale 1ns/100ps

module normal_calc import shade_pkg::*; (
    input  logic      clk,
    input  logic      rst_in,
    input  logic      tri_valid,
    input  triangle_t triangle,
    output logic      norm_valid,
    output normal_t   norm
);

    // edge vectors a = v1 - v0 and b = v2 - v0
    edge_t ax;
    edge_t ay;
    edge_t az;
    edge_t bx;
    edge_t by;
    edge_t bz;
    logic  edge_valid;

    // valid bits follow the two data stages
    always_ff @(posedge clk) begin
        if (rst_in) begin
            edge_valid <= 1'b0;
            norm_valid <= 1'b0;
        end else begin
            edge_valid <= tri_valid;
            norm_valid <= edge_valid;
        end
    end

    // stage one, one extra bit keeps the differences exact
    always_ff @(posedge clk) begin
        if (tri_valid) begin
            ax <= edge_t'(triangle.v1.x) - edge_t'(triangle.v0.x);
            ay <= edge_t'(triangle.v1.y) - edge_t'(triangle.v0.y);
            az <= edge_t'(triangle.v1.z) - edge_t'(triangle.v0.z);
            bx <= edge_t'(triangle.v2.x) - edge_t'(triangle.v0.x);
            by <= edge_t'(triangle.v2.y) - edge_t'(triangle.v0.y);
            bz <= edge_t'(triangle.v2.z) - edge_t'(triangle.v0.z);
        end
    end

    // stage two, n = a x b
    // each product fits in 26 bits, so the difference fits norm_t
    always_ff @(posedge clk) begin
        if (edge_valid) begin
            norm.nx <= norm_t'(ay) * norm_t'(bz) - norm_t'(az) * norm_t'(by);
            norm.ny <= norm_t'(az) * norm_t'(bx) - norm_t'(ax) * norm_t'(bz);
            norm.nz <= norm_t'(ax) * norm_t'(by) - norm_t'(ay) * norm_t'(bx);
        end
    end

endmodule

/* logic/normal_fifo.sv */
`timescale 1ns/100ps

module normal_fifo import shade_pkg::*; (
    input  logic    clk,
    input  logic    rst_in,
    input  logic    norm_valid,
    input  normal_t norm,
    input  logic    pop,
    output logic    empty,
    output normal_t head,
    output logic    overflow
);

    typedef logic [$clog2(fifo_depth)-1:0] ptr_t;
    typedef logic [$clog2(fifo_depth):0]   count_t;

    normal_t mem [fifo_depth];
    ptr_t    wr_ptr;
    ptr_t    rd_ptr;
    count_t  count;
    logic    full;
    logic    wr_en;

    assign empty = (count == '0);
    assign full  = (count == count_t'(fifo_depth));
    assign wr_en = norm_valid && (!full || pop); // a pop frees the slot this cycle
    assign head  = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst_in) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            overflow <= norm_valid && !wr_en; // normal lost
            if (wr_en)
                wr_ptr <= (wr_ptr == ptr_t'(fifo_depth - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == ptr_t'(fifo_depth - 1)) ? '0 : rd_ptr + 1'b1;
            case ({wr_en, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ; // both or neither, level unchanged
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en)
            mem[wr_ptr] <= norm;
    end

endmodule

/* logic/shade_calc.sv */
`timescale 1ns/100ps

module shade_calc import shade_pkg::*; (
    input  logic    clk,
    input  logic    rst_in,
    input  logic    empty,
    input  normal_t head,
    output logic    pop,
    output logic    valid_out,
    output color_t  color_out
);

    // With light (0, 0, -1) the dot product is -nz, so
    //   cos^2 = nz^2 / (nx^2 + ny^2 + nz^2)
    // and the shade index is floor(16 * nz^2 / |n|^2), which lies in 0..16.
    // The division is restoring, one quotient bit per cycle from the MSB.

    typedef logic [$clog2(shade_steps)-1:0] step_t;

    shade_state_t state;
    step_t        step;

    normal_t n_r;   // normal being shaded
    mag_t    sq_x;
    mag_t    sq_y;
    mag_t    sq_z;
    mag_t    mag_sum;
    logic    mag_zero;  // degenerate triangle

    // wide enough for |n|^2 shifted up by shade_steps - 1
    logic [mag_w+index_w-1:0] rem_r;
    logic [mag_w+index_w-1:0] div_r;
    index_t                   quot;

    assign pop     = (state == idle) && !empty;
    assign mag_sum = sq_x + sq_y + sq_z;

    // sequencing
    always_ff @(posedge clk) begin
        if (rst_in) begin
            state     <= idle;
            step      <= '0;
            valid_out <= 1'b0;
        end else begin
            valid_out <= 1'b0;
            case (state)
                idle: begin
                    if (pop)
                        state <= square;
                end
                square: begin
                    state <= sum;
                end
                sum: begin
                    step  <= '0;
                    state <= divide;
                end
                divide: begin
                    step <= step + 1'b1;
                    if (step == step_t'(shade_steps - 1))
                        state <= lookup;
                end
                lookup: begin
                    valid_out <= 1'b1;
                    state     <= idle;
                end
                default: state <= idle;
            endcase
        end
    end

    // datapath
    always_ff @(posedge clk) begin
        case (state)
            idle: begin
                if (pop)
                    n_r <= head;
            end

            square: begin
                // operands sign extended to mag_w, product modulo 2^mag_w is exact
                sq_x <= mag_t'(n_r.nx) * mag_t'(n_r.nx);
                sq_y <= mag_t'(n_r.ny) * mag_t'(n_r.ny);
                sq_z <= mag_t'(n_r.nz) * mag_t'(n_r.nz);
            end

            sum: begin
                mag_zero <= (mag_sum == '0);
                rem_r    <= {{index_w{1'b0}}, sq_z} << 4;  // 16 * nz^2
                // divisor starts at the weight of the top quotient bit
                div_r    <= {{index_w{1'b0}}, mag_sum} << (shade_steps - 1);
                quot     <= '0;
            end

            divide: begin
                if (rem_r >= div_r) begin
                    rem_r <= rem_r - div_r;
                    quot  <= {quot[index_w-2:0], 1'b1};
                end else begin
                    quot  <= {quot[index_w-2:0], 1'b0};
                end
                div_r <= div_r >> 1;  // next lower quotient weight
            end

            lookup: begin
                if (n_r.nz[norm_w-1])
                    color_out <= color_back;    // back facing
                else if (mag_zero)
                    color_out <= '0;            // no normal, quotient meaningless
                else
                    color_out <= color_table[quot];
            end

            default: ;
        endcase
    end

endmodule

/* logic/pixel_shader.sv */
`timescale 1ns/100ps

module pixel_shader import shade_pkg::*; (
    input  logic      clk,
    input  logic      rst_in,
    input  logic      tri_valid,
    input  triangle_t triangle,
    output logic      valid_out,
    output color_t    color_out,
    output logic      overflow
);

    logic    norm_valid;
    normal_t norm;
    logic    empty;
    normal_t head;
    logic    pop;

    // two-stage cross product, one triangle per cycle
    normal_calc i_normal_calc (
        .clk        (clk),
        .rst_in     (rst_in),
        .tri_valid  (tri_valid),
        .triangle   (triangle),
        .norm_valid (norm_valid),
        .norm       (norm)
    );

    // absorbs bursts while the shader works on one normal at a time
    normal_fifo i_normal_fifo (
        .clk        (clk),
        .rst_in     (rst_in),
        .norm_valid (norm_valid),
        .norm       (norm),
        .pop        (pop),
        .empty      (empty),
        .head       (head),
        .overflow   (overflow)
    );

    shade_calc i_shade_calc (
        .clk        (clk),
        .rst_in     (rst_in),
        .empty      (empty),
        .head       (head),
        .pop        (pop),
        .valid_out  (valid_out),
        .color_out  (color_out)
    );

endmodule

/* verif/pixel_shader_assert.sv */
`timescale 1ns/100ps

module pixel_shader_assert import shade_pkg::*; (
    input logic   clk,
    input logic   rst_in,
    input logic   valid_out,
    input color_t color_out,
    input logic   overflow
);

    int fail_count = 0; // watched by the testbench top

    // color_back or any grey level of the table
    function automatic logic known_color(input color_t c);
        logic hit;
        int   i;
        hit = (c == color_back);
        for (i = 0; i < $size(color_table); i++) begin
            if (color_table[i] == c)
                hit = 1'b1;
        end
        return hit;
    endfunction

    single_cycle_valid: assert property (@(posedge clk) disable iff (rst_in)
        valid_out |=> !valid_out)
        else begin
            fail_count++;
            $error("valid_out stayed high for more than one cycle");
        end

    // the buffer must never lose a normal
    no_overflow: assert property (@(posedge clk) disable iff (rst_in)
        !overflow)
        else begin
            fail_count++;
            $error("overflow pulsed, a normal was dropped");
        end

    quiet_after_reset: assert property (@(posedge clk)
        rst_in |=> !valid_out)
        else begin
            fail_count++;
            $error("valid_out high in the cycle after reset");
        end

    legal_color: assert property (@(posedge clk) disable iff (rst_in)
        valid_out |-> known_color(color_out))
        else begin
            fail_count++;
            $error("color_out is neither 255 nor a table grey level");
        end

endmodule

/* verif/pixel_shader_tb.sv */
`timescale 1ns/100ps

module pixel_shader_tb import shade_pkg::*; ();

    localparam int n_directed = 14;
    localparam int n_random   = 24; // per facing direction
    localparam int burst_len  = 8;
    localparam int tri_total  = n_directed + 2 * n_random + burst_len;
    localparam int cycle_cap  = tri_total * 20 + 200;

    logic      clk;
    logic      rst_in;
    logic      tri_valid;
    triangle_t triangle;
    logic      valid_out;
    color_t    color_out;
    logic      overflow;

    color_t exp_q[$];   // expected colors in send order
    color_t exp_head;
    logic   exp_avail;
    int     tri_sent;
    int     results_seen;

    pixel_shader i_pixel_shader (
        .clk       (clk),
        .rst_in    (rst_in),
        .tri_valid (tri_valid),
        .triangle  (triangle),
        .valid_out (valid_out),
        .color_out (color_out),
        .overflow  (overflow)
    );

    bind pixel_shader pixel_shader_assert i_pixel_shader_assert (
        .clk       (clk),
        .rst_in    (rst_in),
        .valid_out (valid_out),
        .color_out (color_out),
        .overflow  (overflow)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_failure(input string why);
        $display("%s", why);
        $display(">>> FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic refresh_head();
        exp_avail = (exp_q.size() > 0);
        if (exp_avail)
            exp_head = exp_q[0];
    endtask

    function automatic longint coord_diff(input coord_t a, input coord_t b);
        return longint'(a) - longint'(b);
    endfunction

    // sign of the z of (v1 - v0) x (v2 - v0) tells the facing
    function automatic longint facing_z(input triangle_t t);
        return coord_diff(t.v1.x, t.v0.x) * coord_diff(t.v2.y, t.v0.y)
             - coord_diff(t.v1.y, t.v0.y) * coord_diff(t.v2.x, t.v0.x);
    endfunction

    // light is (0, 0, -1) so index = floor(16 * nz^2 / |n|^2)
    function automatic color_t expected_color(input triangle_t t);
        longint ax, ay, az, bx, by, bz;
        longint nx, ny, nz, mag;
        index_t idx;
        ax = coord_diff(t.v1.x, t.v0.x);
        ay = coord_diff(t.v1.y, t.v0.y);
        az = coord_diff(t.v1.z, t.v0.z);
        bx = coord_diff(t.v2.x, t.v0.x);
        by = coord_diff(t.v2.y, t.v0.y);
        bz = coord_diff(t.v2.z, t.v0.z);
        nx = ay * bz - az * by;
        ny = az * bx - ax * bz;
        nz = ax * by - ay * bx;
        if (nz < 0)
            return color_back;
        mag = nx * nx + ny * ny + nz * nz;
        if (mag == 0)
            return 8'd0;    // no normal at all
        idx = index_t'((16 * nz * nz) / mag);
        return color_table[idx];
    endfunction

    function automatic vertex_t make_vertex(input int x, input int y, input int z);
        vertex_t v;
        v.x = coord_t'(x);
        v.y = coord_t'(y);
        v.z = coord_t'(z);
        return v;
    endfunction

    function automatic triangle_t make_triangle(input vertex_t a, input vertex_t b,
                                                input vertex_t c);
        triangle_t t;
        t.v0 = a;
        t.v1 = b;
        t.v2 = c;
        return t;
    endfunction

    // edges (s, 0, -x) and (0, s, -y) give a normal along (x, y, s)
    function automatic triangle_t from_direction(input int x, input int y, input int s);
        return make_triangle(make_vertex(0, 0, 0), make_vertex(s, 0, -x),
                             make_vertex(0, s, -y));
    endfunction

    function automatic triangle_t flip(input triangle_t t);
        return make_triangle(t.v0, t.v2, t.v1);    // reverses the winding
    endfunction

    function automatic vertex_t random_vertex();
        vertex_t v;
        v.x = coord_t'($urandom_range(4095));
        v.y = coord_t'($urandom_range(4095));
        v.z = coord_t'($urandom_range(4095));
        return v;
    endfunction

    function automatic triangle_t random_triangle();
        return make_triangle(random_vertex(), random_vertex(), random_vertex());
    endfunction

    task automatic drive_triangle(input triangle_t t);
        @(posedge clk);
        tri_valid <= 1'b1;
        triangle  <= t;
        exp_q.push_back(expected_color(t));
        refresh_head();
        tri_sent++;
    endtask

    task automatic drive_idle();
        @(posedge clk);
        tri_valid <= 1'b0;
    endtask

    task automatic wait_results();
        while (exp_q.size() != 0)
            @(posedge clk);
    endtask

    task automatic shade_one(input triangle_t t);
        drive_triangle(t);
        drive_idle();
        wait_results();
    endtask

    // retire one expected color per result
    always @(posedge clk) begin
        if (!rst_in && valid_out) begin
            if (exp_q.size() > 0)
                void'(exp_q.pop_front());
            results_seen++;
            refresh_head();
        end
    end

    always @(posedge clk) begin
        if (i_pixel_shader.i_pixel_shader_assert.fail_count != 0)
            report_failure("a protocol assertion on pixel_shader failed");
    end

    result_expected: assert property (@(posedge clk) disable iff (rst_in)
        valid_out |-> exp_avail)
        else report_failure("valid_out rose with no triangle outstanding");

    color_check: assert property (@(posedge clk) disable iff (rst_in)
        valid_out && exp_avail |-> color_out == exp_head)
        else report_failure($sformatf("Fail color_out 0x%h expected 0x%h",
                                      $sampled(color_out), $sampled(exp_head)));

    initial begin
        repeat (cycle_cap) @(posedge clk);
        report_failure("timeout, the DUT did not return all results in time");
    end

    initial begin
        triangle_t t;
        int        i;
        void'($urandom(32'h09c6_ec36));
        rst_in       = 1'b1;
        tri_valid    = 1'b0;
        triangle     = '0;
        exp_head     = '0;
        exp_avail    = 1'b0;
        tri_sent     = 0;
        results_seen = 0;
        repeat (2) @(posedge clk);
        rst_in <= 1'b0;
        repeat (6) @(posedge clk);  // valid_out stays low while nothing is sent

        // flat in xy gives index 16
        shade_one(from_direction(0, 0, 1));
        shade_one(make_triangle(make_vertex(100, -50, 7), make_vertex(300, -50, 7),
                                make_vertex(100, 250, 7)));
        shade_one(from_direction(1, 0, 1));     // exactly 8
        shade_one(from_direction(0, 3, 3));
        shade_one(from_direction(19, 0, 11));   // just above 4
        shade_one(from_direction(7, 0, 4));     // just below 4
        shade_one(from_direction(1, 0, 2));     // 12.8
        shade_one(from_direction(4, 0, 7));     // just above 12
        shade_one(from_direction(3, 0, 5));     // just below 12

        // degenerate triangles with an all-zero normal
        shade_one(make_triangle(make_vertex(5, 5, 5), make_vertex(5, 5, 5),
                                make_vertex(5, 5, 5)));
        shade_one(make_triangle(make_vertex(0, 0, 0), make_vertex(1, 2, 3),
                                make_vertex(2, 4, 6)));
        shade_one(make_triangle(make_vertex(-7, 9, 1), make_vertex(-7, 9, 1),
                                make_vertex(40, -3, 8)));
        // edge on with nz = 0 and a nonzero normal
        shade_one(make_triangle(make_vertex(0, 0, 0), make_vertex(10, 0, 0),
                                make_vertex(0, 0, 10)));
        shade_one(flip(from_direction(1, 0, 1)));

        for (i = 0; i < n_random; i++) begin
            t = random_triangle();
            if (facing_z(t) < 0)
                t = flip(t);
            shade_one(t);
        end
        for (i = 0; i < n_random; i++) begin
            t = random_triangle();
            if (facing_z(t) > 0)
                t = flip(t);
            shade_one(t);
        end

        // back-to-back strobes queue up in the buffer
        for (i = 0; i < burst_len; i++)
            drive_triangle(random_triangle());
        drive_idle();
        wait_results();
        repeat (10) @(posedge clk);
        @(negedge clk);     // assertions of the last edge have settled

        if (results_seen == tri_sent && exp_q.size() == 0
                && i_pixel_shader.i_pixel_shader_assert.fail_count == 0) begin
            $display(">>> PASS");
            $finish;
        end else begin
            report_failure("results or protocol checks do not match the triangles sent");
        end
    end

endmodule

/* all.f */
logic/shade_pkg.sv
logic/normal_calc.sv
logic/normal_fifo.sv
logic/shade_calc.sv
logic/pixel_shader.sv
verif/pixel_shader_assert.sv
verif/pixel_shader_tb.sv

/* Makefile */
# Verilator flow for the flat-shading unit
# every variable below can be overridden on the command line

VERILATOR  ?= verilator
TOP        ?= pixel_shader_tb
FILELIST   ?= all.f
BUILD_DIR  ?= build
LOG        ?= sim.log
JOBS       ?= 0
VL_FLAGS   ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing -Wall
SIM_ARGS   ?= +verilator+error+limit+100

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VL_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# the log decides the result, the simulator exit code is not trusted
run: build
	./$(SIM_BIN) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@if grep -q '^>>> PASS$$' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
